//--- fpNextAfterUnit.f
hw/fp64Pkg.sv
hw/fpClassify64.sv
hw/fpCompare64.sv
hw/fpNextAfter64.sv
hw/fpSyncFifo.sv
hw/fpAxiRegSlave.sv
hw/fpNextEngine.sv
hw/fpNextAfterUnit.sv
testbench/fpNextAfterUnit_assert.sv
testbench/tb_fpNextAfterUnit.sv

//--- hw/fp64Pkg.sv
/*
 * Shared types for the double-precision next-value unit: the IEEE-754 format,
 * compare flags, opcodes, FIFO payloads, the register map and AXI responses.
 */
`default_nettype none

package fp64Pkg;

	// ==================================================
	// Double-precision format
	// ==================================================

	// Top bit index of the exponent and fraction fields
	localparam int EMSB = 10;
	localparam int FMSB = 51;

	// Sign, biased exponent and stored fraction, 64 bits in all
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [FMSB:0] sig;
	} FP64;

	// Exactly one flag is set per comparison
	typedef struct packed {
		logic lt;
		logic eq;
		logic gt;
		logic unordered;
	} FpCmpResult;

	// ==================================================
	// Commands and FIFO payloads
	// ==================================================

	// Code 2'b11 is illegal and is refused by the register slave
	typedef enum logic [1:0] {
		opNextAfter = 2'd0,
		opNextUp    = 2'd1,
		opNextDown  = 2'd2
	} FpOpcode;

	typedef struct packed {
		FpOpcode opcode;
		FP64 a;
		FP64 b;
	} FpRequest;

	typedef struct packed {
		FP64 value;
	} FpResult;

	// ==================================================
	// Register map and bus responses
	// ==================================================

	// Byte addresses of the 32-bit registers
	typedef enum logic [4:0] {
		regALo    = 5'h00,
		regAHi    = 5'h04,
		regBLo    = 5'h08,
		regBHi    = 5'h0C,
		regCmd    = 5'h10,
		regStatus = 5'h14,
		regResLo  = 5'h18,
		regResHi  = 5'h1C
	} FpRegAddr;

	typedef enum logic [1:0] {
		respOkay   = 2'b00,
		respSlvErr = 2'b10
	} AxiResp;

endpackage

`default_nettype wire

//--- hw/fpAxiRegSlave.sv
/*
 * AXI4-Lite register slave. Holds operands A and B, turns a command write
 * into a request push and serves results, popping on the high-word read.
 */
`timescale 1ns/10ps
`default_nettype none

module fpAxiRegSlave
	import fp64Pkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	// Write address and data, accepted together
	input  logic [4:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output AxiResp      bresp,
	output logic        bvalid,
	input  logic        bready,
	// Read address and data
	input  logic [4:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output AxiResp      rresp,
	output logic        rvalid,
	input  logic        rready,
	// Request FIFO write side
	output logic        reqPush,
	output FpRequest    reqData,
	input  logic        reqFull,
	// Result FIFO read side
	output logic        resPop,
	input  FpResult     resData,
	input  logic        resEmpty,
	input  logic [2:0]  resCount
);

	typedef enum logic {wrIdle, wrRespond} WrState;
	typedef enum logic {rdIdle, rdRespond} RdState;

	WrState wrState;
	RdState rdState;
	logic wrAccept;
	logic wrHandshake;
	logic rdHandshake;

	FP64 regA;
	FP64 regB;
	FpOpcode cmdOp;
	logic cmdWrite;
	logic [31:0] rdWord;
	AxiResp rdResp;

	// ==================================================
	// Write channel
	// ==================================================

	// One ready register serves both AW and W since they are taken together
	assign awready     = wrAccept;
	assign wready      = wrAccept;
	assign wrHandshake = wrAccept && awvalid && wvalid;
	assign bvalid      = (wrState == wrRespond);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrState  <= wrIdle;
			wrAccept <= 1'b0;
		end else begin
			wrAccept <= 1'b0;
			unique case (wrState)
				wrIdle: begin
					if (wrHandshake) begin
						wrState <= wrRespond;
					end else if (awvalid && wvalid) begin
						wrAccept <= 1'b1;
					end
				end
				wrRespond: begin
					if (bready) begin
						wrState <= wrIdle;
					end
				end
			endcase
		end
	end

	// A command takes its opcode from the low bits and the current operands
	assign cmdOp    = FpOpcode'(wdata[1:0]);
	assign cmdWrite = wrHandshake && (FpRegAddr'(awaddr) == regCmd);
	assign reqPush  = cmdWrite && !reqFull &&
		(cmdOp inside {opNextAfter, opNextUp, opNextDown});
	assign reqData  = '{opcode: cmdOp, a: regA, b: regB};

	// Operand registers and the B response
	always_ff @(posedge clk) begin
		if (wrHandshake) begin
			case (FpRegAddr'(awaddr))
				regALo: regA[31:0]  <= wdata;
				regAHi: regA[63:32] <= wdata;
				regBLo: regB[31:0]  <= wdata;
				regBHi: regB[63:32] <= wdata;
				default: ;
			endcase
			// A refused command is either full or illegal
			bresp <= (cmdWrite && !reqPush) ? respSlvErr : respOkay;
		end
		if (rdHandshake) begin
			rdata <= rdWord;
			rresp <= rdResp;
		end
	end

	// ==================================================
	// Read channel
	// ==================================================

	assign rdHandshake = arready && arvalid;
	assign rvalid      = (rdState == rdRespond);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdState <= rdIdle;
			arready <= 1'b0;
		end else begin
			arready <= 1'b0;
			unique case (rdState)
				rdIdle: begin
					if (rdHandshake) begin
						rdState <= rdRespond;
					end else if (arvalid) begin
						arready <= 1'b1;
					end
				end
				rdRespond: begin
					if (rready) begin
						rdState <= rdIdle;
					end
				end
			endcase
		end
	end

	// Register decode for the read data
	always_comb begin
		rdWord = '0;
		rdResp = respOkay;
		case (FpRegAddr'(araddr))
			regALo:    rdWord = regA[31:0];
			regAHi:    rdWord = regA[63:32];
			regBLo:    rdWord = regB[31:0];
			regBHi:    rdWord = regB[63:32];
			regStatus: rdWord = {21'd0, resCount, 6'd0, reqFull, !resEmpty};
			regResLo: begin
				if (resEmpty) rdResp = respSlvErr;
				else rdWord = resData.value[31:0];
			end
			regResHi: begin
				if (resEmpty) rdResp = respSlvErr;
				else rdWord = resData.value[63:32];
			end
			default: ;
		endcase
	end

	// Only the high word consumes the result
	assign resPop = rdHandshake && (FpRegAddr'(araddr) == regResHi) && !resEmpty;

endmodule

`default_nettype wire

//--- hw/fpClassify64.sv
/*
 * Combinational decode of one double into NaN, zero and infinity flags.
 * Used by the comparator and the nextafter datapath.
 */
`timescale 1ns/10ps
`default_nettype none

module fpClassify64
	import fp64Pkg::*;
(
	input  FP64  value,
	output logic isNan,
	output logic isZero,
	output logic isInf
);

	// Field summaries shared by all three flags
	logic expAllOnes;
	logic expZero;
	logic fracZero;

	assign expAllOnes = &value.exp;
	assign expZero    = ~|value.exp;
	assign fracZero   = ~|value.sig;

	// A NaN has the top exponent and a nonzero fraction
	// Quiet and signalling NaNs are not told apart here
	assign isNan = expAllOnes && !fracZero;

	// Infinity has the top exponent with an empty fraction
	assign isInf = expAllOnes && fracZero;

	// Both zeros count, the sign is ignored
	assign isZero = expZero && fracZero;

endmodule

`default_nettype wire

//--- hw/fpCompare64.sv
/*
 * Orders two doubles into less, equal, greater or unordered.
 * Positive and negative zero compare equal, any NaN gives unordered.
 */
`timescale 1ns/10ps
`default_nettype none

module fpCompare64
	import fp64Pkg::*;
(
	input  FP64        a,
	input  FP64        b,
	output FpCmpResult cmp
);

	logic aNan;
	logic bNan;
	logic aZero;
	logic bZero;

	// Magnitude is the exponent and fraction taken as one unsigned number
	logic [EMSB+FMSB+1:0] magA;
	logic [EMSB+FMSB+1:0] magB;

	fpClassify64 i_classA (.value(a), .isNan(aNan), .isZero(aZero), .isInf());
	fpClassify64 i_classB (.value(b), .isNan(bNan), .isZero(bZero), .isInf());

	assign magA = {a.exp, a.sig};
	assign magB = {b.exp, b.sig};

	always_comb begin
		cmp = '0;
		if (aNan || bNan) begin
			cmp.unordered = 1'b1;
		end else if ((aZero && bZero) || (a == b)) begin
			cmp.eq = 1'b1;
		end else if (a.sign != b.sign) begin
			// Signs differ and not both zero, so the negative one is smaller
			cmp.lt = a.sign;
			cmp.gt = !a.sign;
		end else if (!a.sign) begin
			cmp.lt = magA < magB;
			cmp.gt = magA > magB;
		end else begin
			// Both negative, so a larger magnitude means a smaller value
			cmp.lt = magA > magB;
			cmp.gt = magA < magB;
		end
	end

endmodule

`default_nettype wire

//--- hw/fpNextAfter64.sv
/*
 * Registered nextafter(a, b) for doubles. The result is taken on a clock edge
 * with ce high and holds otherwise, so it is valid the cycle after ce.
 */
`timescale 1ns/10ps
`default_nettype none

module fpNextAfter64
	import fp64Pkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  logic ce,
	input  FP64  a,
	input  FP64  b,
	output FP64  result
);

	FpCmpResult cmp;
	logic aNan;
	logic aZero;
	logic bNan;

	// Neighbours of a as raw bit patterns
	FP64 aPlus1;
	FP64 aMinus1;
	FP64 nextVal;
	logic awayFromZero;

	fpCompare64 i_compare (.a(a), .b(b), .cmp(cmp));
	fpClassify64 i_classA (.value(a), .isNan(aNan), .isZero(aZero), .isInf());
	fpClassify64 i_classB (.value(b), .isNan(bNan), .isZero(), .isInf());

	// Stepping the pattern walks the format in order of magnitude
	// Largest finite plus one lands on infinity, infinity minus one on largest finite
	assign aPlus1  = FP64'(a + 64'd1);
	assign aMinus1 = FP64'(a - 64'd1);

	// Target lies further from zero than a, on the same side
	assign awayFromZero = (cmp.lt && !a.sign) || (cmp.gt && a.sign);

	always_comb begin
		if (cmp.unordered) begin
			// A NaN is passed through, a's own NaN wins over b's
			nextVal = (bNan && !aNan) ? b : a;
		end else if (cmp.eq) begin
			nextVal = a;
		end else if (aZero) begin
			// Smallest subnormal on the side of b
			nextVal = '{sign: b.sign, exp: '0, sig: {{FMSB{1'b0}}, 1'b1}};
		end else if (awayFromZero) begin
			nextVal = aPlus1;
		end else begin
			nextVal = aMinus1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			result <= '0;
		end else if (ce) begin
			result <= nextVal;
		end
	end

endmodule

`default_nettype wire

//--- hw/fpNextAfterUnit.sv
/*
 * Top level of the next-representable-value unit. The AXI4-Lite slave feeds
 * the request FIFO, the engine drains it into the result FIFO.
 */
`timescale 1ns/10ps
`default_nettype none

module fpNextAfterUnit
	import fp64Pkg::*;
#(
	parameter int REQ_DEPTH = 4,
	parameter int RES_DEPTH = 4
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic [4:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output AxiResp      bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [4:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output AxiResp      rresp,
	output logic        rvalid,
	input  logic        rready
);

	// Request path, slave to engine
	logic reqPush;
	logic reqPop;
	logic reqEmpty;
	logic reqFull;
	FpRequest reqPushData;
	FpRequest reqPopData;
	logic [$clog2(REQ_DEPTH+1)-1:0] reqCount;

	// Result path, engine to slave
	logic resPush;
	logic resPop;
	logic resEmpty;
	FpResult resPushData;
	FpResult resPopData;
	logic [$clog2(RES_DEPTH+1)-1:0] resCount;

	fpAxiRegSlave i_fpAxiRegSlave (
		.clk(clk), .rstN(rstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.reqPush(reqPush), .reqData(reqPushData), .reqFull(reqFull),
		.resPop(resPop), .resData(resPopData), .resEmpty(resEmpty), .resCount(resCount)
	);

	fpSyncFifo #(.DEPTH(REQ_DEPTH), .T(FpRequest)) i_reqFifo (
		.clk(clk), .rstN(rstN),
		.push(reqPush), .pushData(reqPushData), .pop(reqPop), .popData(reqPopData),
		.empty(reqEmpty), .full(reqFull), .count(reqCount)
	);

	// Full is not needed here since the engine works from the count
	fpSyncFifo #(.DEPTH(RES_DEPTH), .T(FpResult)) i_resFifo (
		.clk(clk), .rstN(rstN),
		.push(resPush), .pushData(resPushData), .pop(resPop), .popData(resPopData),
		.empty(resEmpty), .full(), .count(resCount)
	);

	fpNextEngine #(.RES_DEPTH(RES_DEPTH)) i_fpNextEngine (
		.clk(clk), .rstN(rstN),
		.reqData(reqPopData), .reqEmpty(reqEmpty), .resCount(resCount),
		.reqPop(reqPop), .resPush(resPush), .resData(resPushData)
	);

endmodule

`default_nettype wire

//--- hw/fpNextEngine.sv
/*
 * Execution engine. Pops one request per cycle when the result FIFO has a
 * free slot, runs the datapath and pushes its result on the next cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module fpNextEngine
	import fp64Pkg::*;
#(
	parameter int RES_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rstN,
	input  FpRequest reqData,
	input  logic     reqEmpty,
	input  logic [$clog2(RES_DEPTH+1)-1:0] resCount,
	output logic     reqPop,
	output logic     resPush,
	output FpResult  resData
);

	logic issue;
	logic inFlight;
	FP64 target;
	FP64 nextVal;

	// Credit check counts the result still in the datapath register
	assign issue  = !reqEmpty && ((int'(resCount) + int'(inFlight)) < RES_DEPTH);
	assign reqPop = issue;

	// nextUp and nextDown are nextafter toward the matching infinity
	always_comb begin
		unique case (reqData.opcode)
			opNextUp:   target = '{sign: 1'b0, exp: '1, sig: '0};
			opNextDown: target = '{sign: 1'b1, exp: '1, sig: '0};
			default:    target = reqData.b;
		endcase
	end

	fpNextAfter64 i_nextAfter (
		.clk(clk),
		.rstN(rstN),
		.ce(issue),
		.a(reqData.a),
		.b(target),
		.result(nextVal)
	);

	// The flag follows the datapath register by exactly one cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			inFlight <= 1'b0;
		end else begin
			inFlight <= issue;
		end
	end

	assign resPush       = inFlight;
	assign resData.value = nextVal;

endmodule

`default_nettype wire

//--- hw/fpSyncFifo.sv
/*
 * Synchronous FIFO of any packed type with an occupancy count.
 * The head is shown on popData without a pop; push and pop may share a cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module fpSyncFifo #(
	parameter int DEPTH = 4,
	parameter type T = logic
) (
	input  logic clk,
	input  logic rstN,
	input  logic push,
	input  T     pushData,
	input  logic pop,
	output T     popData,
	output logic empty,
	output logic full,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	// Keep one pointer bit even for a single-entry FIFO
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;

	// The storage array is written only at the write pointer
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			// A simultaneous push and pop leaves the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	assign popData = mem[rdPtr];
	assign empty   = (count == '0);
	assign full    = (count == ($clog2(DEPTH+1))'(DEPTH));

endmodule

`default_nettype wire

//--- testbench/fpNextAfterUnit_assert.sv
/*
 * Concurrent checks bound into the unit top level: AXI response channels
 * hold until taken, FIFO counts stay within depth, no push into a full FIFO.
 */
`timescale 1ns/10ps
`default_nettype none

module fpNextAfterUnit_assert #(
	parameter int REQ_DEPTH = 4,
	parameter int RES_DEPTH = 4
) (
	input logic clk,
	input logic rstN,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic [31:0] rdata,
	input logic [$clog2(REQ_DEPTH+1)-1:0] reqCount,
	input logic [$clog2(RES_DEPTH+1)-1:0] resCount,
	input logic resPush
);

	// A response stays up, with the same read data, until the host takes it
	assertBHold: assert property (@(posedge clk) disable iff (!rstN)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	assertRHold: assert property (@(posedge clk) disable iff (!rstN)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed before rready");

	// Occupancy never runs past the configured depth
	assertReqCount: assert property (@(posedge clk) disable iff (!rstN)
		reqCount <= REQ_DEPTH)
		else $error("request FIFO count above depth");

	assertResCount: assert property (@(posedge clk) disable iff (!rstN)
		resCount <= RES_DEPTH)
		else $error("result FIFO count above depth");

	// The credit rule leaves a free slot for every result in flight
	assertNoFullPush: assert property (@(posedge clk) disable iff (!rstN)
		resPush |-> resCount < RES_DEPTH)
		else $error("engine pushed into a full result FIFO");

endmodule

bind fpNextAfterUnit fpNextAfterUnit_assert #(
	.REQ_DEPTH(REQ_DEPTH),
	.RES_DEPTH(RES_DEPTH)
) i_fpNextAfterUnit_assert (
	.clk(clk), .rstN(rstN),
	.bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready), .rdata(rdata),
	.reqCount(reqCount), .resCount(resCount),
	.resPush(resPush)
);

`default_nettype wire

//--- testbench/tb_fpNextAfterUnit.sv
/*
 * Testbench for the next-value unit. Drives AXI4-Lite on the falling edge,
 * draws operands from an xorshift generator and checks every result word
 * against a reference model of the nextafter rules.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_fpNextAfterUnit
	import fp64Pkg::*;
;

	localparam int REQ_DEPTH = 4;
	localparam int RES_DEPTH = 4;
	localparam int N_RANDOM  = 200;
	localparam int N_UPDOWN  = 40;
	localparam int N_SPECIAL = 9;
	localparam int N_NAN     = 4;
	localparam int N_BURST   = REQ_DEPTH + RES_DEPTH + 1;
	// Each operation is 4 operand writes, a command, a status poll and 2 reads
	localparam int TXN_TOTAL = 3 + 8 * (N_RANDOM + N_UPDOWN + N_SPECIAL + N_NAN) +
		5 * N_BURST + 2 + 3 * (N_BURST - 1) + 6;
	localparam int CYCLE_LIMIT = 40 * TXN_TOTAL;

	localparam logic [63:0] POS_INF = 64'h7FF0_0000_0000_0000;
	localparam logic [63:0] NEG_INF = 64'hFFF0_0000_0000_0000;
	localparam logic [63:0] MAX_FIN = 64'h7FEF_FFFF_FFFF_FFFF;

	logic clk;
	logic rstN;
	logic [4:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	AxiResp bresp;
	logic bvalid;
	logic bready;
	logic [4:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	AxiResp rresp;
	logic rvalid;
	logic rready;

	logic [31:0] rngState;
	int errorCount;
	int checkCount;
	int cycleCount;
	FP64 expected[$];

	fpNextAfterUnit #(.REQ_DEPTH(REQ_DEPTH), .RES_DEPTH(RES_DEPTH)) i_fpNextAfterUnit (
		.clk(clk), .rstN(rstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Hard stop if a handshake never completes
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ==================================================
	// Stimulus source and reference model
	// ==================================================

	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// Five of eight draws land on a special value of random sign
	function automatic FP64 randOperand();
		logic [31:0] r;
		logic [31:0] hi;
		logic [31:0] lo;
		r = nextRand();
		hi = nextRand();
		lo = nextRand();
		case (r[2:0])
			3'd0: return {r[31], 63'd0};
			3'd1: return {r[31], 11'h7FF, 52'd0};
			3'd2: return {r[31], 11'h7FF, 1'b1, hi, lo[18:0]};
			3'd3: return {r[31], MAX_FIN[62:0]};
			3'd4: return {r[31], 63'd1};
			default: return {hi, lo};
		endcase
	endfunction

	function automatic logic isNanVal(input FP64 x);
		return (x.exp == 11'h7FF) && (x.sig != 52'd0);
	endfunction

	// Signed position on the real line, both zeros map to 0
	function automatic logic signed [64:0] orderKey(input FP64 x);
		logic signed [64:0] mag;
		mag = {2'b00, x[62:0]};
		return x.sign ? -mag : mag;
	endfunction

	function automatic FP64 modelNext(input FpOpcode op, input FP64 a, input FP64 b);
		FP64 t;
		logic signed [64:0] ka;
		logic signed [64:0] kb;
		t = (op == opNextUp) ? POS_INF : (op == opNextDown) ? NEG_INF : b;
		if (isNanVal(a)) return a;
		if (isNanVal(t)) return t;
		ka = orderKey(a);
		kb = orderKey(t);
		if (ka == kb) return a;
		if (ka == 65'sd0) return {t.sign, 11'd0, 52'd1};
		// Away from zero when the target sits on the outer side of a
		if ((ka < kb) != a.sign) return FP64'(a + 64'd1);
		return FP64'(a - 64'd1);
	endfunction

	// ==================================================
	// Checking and AXI bus tasks
	// ==================================================

	task automatic checkValue(input logic [63:0] got, input logic [63:0] want,
			input string msg);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, got, want);
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		$display("%s done, %0d errors", name, errorCount - errorsBefore);
	endtask

	// Entered and left on a falling edge
	task automatic axiWrite(input logic [4:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) @(negedge clk);
		resp = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [4:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		araddr = addr;
		arvalid = 1'b1;
		do @(negedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk);
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic writeOperands(input FP64 a, input FP64 b);
		logic [1:0] resp;
		axiWrite(regALo, a[31:0], resp);
		axiWrite(regAHi, a[63:32], resp);
		axiWrite(regBLo, b[31:0], resp);
		axiWrite(regBHi, b[63:32], resp);
	endtask

	// Polls status bit 0 a bounded number of times
	task automatic waitResult();
		logic [31:0] status;
		logic [1:0] resp;
		int tries;
		tries = 0;
		do begin
			axiRead(regStatus, status, resp);
			tries++;
		end while (!status[0] && tries < 20);
		if (!status[0]) begin
			errorCount++;
			$display("No result became available after %0d status reads", tries);
		end
	endtask

	// Reads both words of the head result and compares with the oldest expectation
	task automatic collectResult(input string msg);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [1:0] respLo;
		logic [1:0] respHi;
		FP64 want;
		waitResult();
		axiRead(regResLo, lo, respLo);
		axiRead(regResHi, hi, respHi);
		want = expected.pop_front();
		checkValue(respLo, respOkay, {msg, " low word response"});
		checkValue(respHi, respOkay, {msg, " high word response"});
		checkValue({hi, lo}, want, msg);
	endtask

	task automatic runOp(input FpOpcode op, input FP64 a, input FP64 b, input string msg);
		logic [1:0] resp;
		writeOperands(a, b);
		axiWrite(regCmd, {30'd0, op}, resp);
		checkValue(resp, respOkay, {msg, " command response"});
		expected.push_back(modelNext(op, a, b));
		collectResult(msg);
	endtask

	// Pins the model to a known answer, then runs the same case on the DUT
	task automatic specialCase(input FpOpcode op, input FP64 a, input FP64 want,
			input string msg);
		checkValue(modelNext(op, a, a), want, {msg, " reference"});
		runOp(op, a, a, msg);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		logic [31:0] data;
		logic [1:0] resp;
		logic [31:0] r;
		FP64 a;
		FP64 b;
		int errBefore;

		rngState = 32'h95d6d862;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		rstN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		// Empty unit after reset
		errBefore = errorCount;
		axiRead(regStatus, data, resp);
		checkValue(data, 0, "status after reset");
		axiRead(regResHi, data, resp);
		checkValue(resp, respSlvErr, "result read when empty");
		checkValue(data, 0, "result data when empty");
		finishTest("Reset state", errBefore);

		errBefore = errorCount;
		for (int i = 0; i < N_RANDOM; i++) begin
			a = randOperand();
			r = nextRand();
			b = (r[2:0] == 3'd0) ? a : randOperand();
			runOp(opNextAfter, a, b, $sformatf("nextafter %0d", i));
		end
		finishTest("Random nextafter", errBefore);

		errBefore = errorCount;
		for (int i = 0; i < N_UPDOWN; i++) begin
			a = randOperand();
			r = nextRand();
			runOp(r[0] ? opNextUp : opNextDown, a, a, $sformatf("up/down %0d", i));
		end
		specialCase(opNextUp, 64'h0, 64'h1, "nextUp of +0");
		specialCase(opNextUp, 64'h8000_0000_0000_0000, 64'h1, "nextUp of -0");
		specialCase(opNextDown, 64'h0, 64'h8000_0000_0000_0001, "nextDown of +0");
		specialCase(opNextUp, MAX_FIN, POS_INF, "nextUp of largest finite");
		specialCase(opNextDown, {1'b1, MAX_FIN[62:0]}, NEG_INF, "nextDown of -largest");
		specialCase(opNextDown, POS_INF, MAX_FIN, "nextDown of +inf");
		specialCase(opNextUp, NEG_INF, {1'b1, MAX_FIN[62:0]}, "nextUp of -inf");
		specialCase(opNextDown, 64'h1, 64'h0, "nextDown of smallest subnormal");
		specialCase(opNextUp, POS_INF, POS_INF, "nextUp of +inf");
		finishTest("nextUp and nextDown", errBefore);

		// Fill both FIFOs, the last command finds the request FIFO full
		errBefore = errorCount;
		for (int i = 0; i < N_BURST; i++) begin
			a = randOperand();
			b = randOperand();
			writeOperands(a, b);
			axiWrite(regCmd, {30'd0, opNextAfter}, resp);
			if (i < N_BURST - 1) begin
				checkValue(resp, respOkay, $sformatf("burst command %0d", i));
				expected.push_back(modelNext(opNextAfter, a, b));
			end else begin
				checkValue(resp, respSlvErr, "command into full FIFO");
			end
		end
		axiRead(regStatus, data, resp);
		checkValue(data[10:8], RES_DEPTH, "result count when backed up");
		checkValue(data[1:0], 2'b11, "status flags when backed up");
		for (int i = 0; i < N_BURST - 1; i++) begin
			collectResult($sformatf("drain %0d", i));
		end
		axiRead(regStatus, data, resp);
		checkValue(data, 0, "status after drain");
		finishTest("Back-pressure", errBefore);

		errBefore = errorCount;
		writeOperands(64'h3FF0_0000_0000_0000, POS_INF);
		axiWrite(regCmd, 32'd3, resp);
		checkValue(resp, respSlvErr, "illegal opcode response");
		axiRead(regStatus, data, resp);
		checkValue(data, 0, "status after illegal opcode");
		// Quiet and signalling payloads both pass through untouched
		runOp(opNextAfter, 64'h7FF8_0000_0000_1234, 64'h3FF0_0000_0000_0000, "NaN a");
		runOp(opNextAfter, 64'h3FF0_0000_0000_0000, 64'hFFF0_0000_0000_0001, "NaN b");
		runOp(opNextAfter, 64'h7FF0_0000_0000_0042, 64'hFFF8_0000_0000_0000, "NaN a and b");
		runOp(opNextUp, 64'hFFF8_0000_0000_0007, 64'h0, "nextUp of NaN");
		finishTest("Illegal opcode and NaN", errBefore);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
